/* streamReader.f */
+incdir+.
streamReaderPkg.sv
ramPortIf.sv
bufferRam.sv
fetchCtrl.sv
readAddrGen.sv
streamReader.sv
streamReader_properties.sv
streamReader_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the streamReader testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module streamReader_tb -f streamReader.f -o simStreamReader

./obj_dir/simStreamReader | tee sim.log

if grep -q "SIMULATION FAILED" sim.log || ! grep -q "SIMULATION PASSED" sim.log; then
   echo "run failed, see sim.log"
   exit 1
fi
echo "run passed"

/* streamReader_tb.sv */
`timescale 1ns/1ns

`include "streamReader_cfg.svh"

module streamReader_tb;

   typedef logic [`SR_DATA_W-1:0]      word_t;
   typedef logic [`SR_ADDR_W-1:0]      addr_t;
   typedef logic [`SR_EXT_ADDR_W-1:0]  ext_t;
   typedef logic [`SR_SIZE_W-1:0]      size_t;
   typedef logic [`SR_PERIOD_W-1:0]    per_t;

   localparam int DEPTH      = 1 << `SR_ADDR_W;
   localparam int DONE_LIMIT = 20000;
   localparam int CLK_PERIOD = 8;

   logic   clk;
   logic   rst;
   logic   run;
   logic   done;
   logic   busValid;
   ext_t   busAddr;
   logic   busReady;
   word_t  busRdata;
   logic   outValid;
   word_t  outData;
   ext_t   extAddr;
   addr_t  intAddr;
   size_t  size;
   logic   pingPong;
   addr_t  iterations;
   per_t   period;
   per_t   duty;
   addr_t  start;
   addr_t  shift;
   addr_t  incr;
   per_t   delay;
   logic   reverse;

   // buffer model and expected output stream
   word_t  model [0:DEPTH-1];
   word_t  expQ [$];
   int     cycQ [$];
   time    runStart;
   logic   modelBank;
   addr_t  wrAddr;
   int     xferCount;
   int     outCount;
   int     readyPct;
   int     errors;
   int     timeouts;

   streamReader i_streamReader (.*);

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #(CLK_PERIOD / 2) clk = ~clk;
      end
   end

   // stands in for the external memory contents
   function automatic word_t hashWord(input ext_t a);
      return (a * 32'h9E3779B1) ^ (a >> 13) ^ 32'h5A5A0F0F;
   endfunction

   function automatic addr_t reverseBits(input addr_t a);
      addr_t r;
      for (int i = 0; i < `SR_ADDR_W; i++)
      begin
         r[`SR_ADDR_W-1-i] = a[i];
      end
      return r;
   endfunction

   function automatic int pick(input int lo, input int hi);
      return lo + int'($urandom % (hi - lo + 1));
   endfunction

   task automatic checkWord(input word_t got, input word_t exp, input string what);
      if (got !== exp)
      begin
         errors++;
         $display("[FAIL] %0t: %s got %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic checkFlag(input logic got, input logic exp, input string what);
      if (got !== exp)
      begin
         errors++;
         $display("[FAIL] %0t: %s got %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic verifyBusAddr(input ext_t got, input ext_t exp);
      if (got !== exp)
      begin
         errors++;
         $display("[FAIL] %0t: busAddr got %h, expected %h", $time, got, exp);
      end
   endtask

   task automatic compareCount(input int got, input int exp, input string what);
      if (got != exp)
      begin
         errors++;
         $display("[FAIL] %0t: %s got %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic awaitDone();
      int n;
      n = 0;
      while (done !== 1'b1 && n < DONE_LIMIT)
      begin
         @(negedge clk);
         n++;
      end
      if (done !== 1'b1)
      begin
         timeouts++;
         $display("timeout: done stayed low for %0d cycles at %0t", DONE_LIMIT, $time);
      end
   endtask

   task automatic randomizePattern();
      period     = per_t'(pick(1, 12));
      duty       = per_t'(pick(0, 14));
      iterations = addr_t'(pick(1, 10));
      delay      = per_t'(pick(0, 20));
      start      = addr_t'(pick(0, DEPTH - 1));
      shift      = addr_t'(pick(0, DEPTH - 1));
      incr       = addr_t'(pick(0, DEPTH - 1));
   endtask

   // predicts the read stream and runs one pass up to done
   task automatic executeRun();
      addr_t a;
      addr_t issued;
      int    expCount;
      if (timeouts != 0)
      begin
         return;
      end
      modelBank = pingPong ? ~modelBank : 1'b0;
      xferCount = 0;
      outCount  = 0;
      a = start;
      for (int it = 0; it < int'(iterations); it++)
      begin
         for (int p = 0; p < int'(period); p++)
         begin
            if (p < int'(duty))
            begin
               issued = a;
               if (pingPong)
               begin
                  issued[`SR_ADDR_W-1] = ~modelBank;
               end
               if (reverse)
               begin
                  issued = reverseBits(issued);
               end
               expQ.push_back(model[issued]);
               // run edge, delay, then outValid one cycle after the read
               cycQ.push_back(2 + int'(delay) + it * int'(period) + p);
               a = a + incr;
            end
            if (p == int'(period) - 1)
            begin
               a = a + shift;
            end
         end
      end
      expCount = int'(iterations) * ((duty < period) ? int'(duty) : int'(period));
      runStart = $time;
      run = 1'b1;
      @(negedge clk);
      run = 1'b0;
      checkFlag(done, 1'b0, "done after run");
      awaitDone();
      if (timeouts == 0)
      begin
         @(negedge clk);
         compareCount(xferCount, int'(size), "bus transfers");
         compareCount(outCount, expCount, "outValid pulses");
         if (expQ.size() != 0)
         begin
            errors++;
            $display("done rose at %0t with %0d predicted words not yet read",
               $time, expQ.size());
            expQ.delete();
            cycQ.delete();
         end
      end
   endtask

   // memory side of the bus and the model writes
   initial
   begin
      forever
      begin
         @(negedge clk);
         if (!rst)
         begin
            busReady = (($urandom % 100) < readyPct);
            busRdata = hashWord(busAddr);
            if (busValid && busReady)
            begin
               verifyBusAddr(busAddr, extAddr + ext_t'(xferCount));
               wrAddr = intAddr + addr_t'(xferCount);
               if (pingPong)
               begin
                  wrAddr[`SR_ADDR_W-1] = modelBank;
               end
               model[wrAddr] = hashWord(extAddr + ext_t'(xferCount));
               xferCount++;
            end
         end
      end
   end

   initial
   begin
      forever
      begin
         @(negedge clk);
         if (!rst && outValid)
         begin
            outCount++;
            if (expQ.size() == 0)
            begin
               errors++;
               $display("outValid high at %0t with no predicted word", $time);
            end
            else
            begin
               checkWord(outData, expQ.pop_front(), "outData");
               compareCount(int'(($time - runStart) / CLK_PERIOD), cycQ.pop_front(),
                  "outValid cycle");
            end
         end
      end
   end

   initial
   begin
      void'($urandom(32'he517));
      rst        = 1'b1;
      run        = 1'b0;
      busReady   = 1'b0;
      busRdata   = '0;
      extAddr    = '0;
      intAddr    = '0;
      size       = '0;
      pingPong   = 1'b0;
      iterations = '0;
      period     = '0;
      duty       = '0;
      start      = '0;
      shift      = '0;
      incr       = '0;
      delay      = '0;
      reverse    = 1'b0;
      modelBank  = 1'b0;
      runStart   = 0;
      readyPct   = 70;
      errors     = 0;
      timeouts   = 0;
      repeat (10) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      checkFlag(done, 1'b1, "done after reset");
      checkFlag(busValid, 1'b0, "busValid after reset");
      checkFlag(outValid, 1'b0, "outValid after reset");

      // fill the whole buffer first
      extAddr = ext_t'($urandom);
      size    = size_t'(DEPTH);
      executeRun();

      // plain fetch followed by an identity read of the same words
      extAddr = ext_t'($urandom);
      intAddr = addr_t'(pick(0, DEPTH - 1));
      size    = size_t'(pick(1, 512));
      executeRun();
      start      = intAddr;
      incr       = addr_t'(1);
      period     = per_t'(size);
      duty       = period;
      iterations = addr_t'(1);
      size       = '0;
      executeRun();

      pingPong = 1'b1;
      repeat (4)
      begin
         extAddr    = ext_t'($urandom);
         intAddr    = addr_t'(pick(0, DEPTH - 1));
         size       = size_t'(pick(1, 512));
         start      = addr_t'(pick(0, DEPTH - 1));
         period     = per_t'(pick(1, 16));
         duty       = period;
         iterations = addr_t'(pick(1, 16));
         executeRun();
      end

      pingPong = 1'b0;
      size     = '0;
      repeat (6)
      begin
         randomizePattern();
         executeRun();
      end

      reverse = 1'b1;
      repeat (4)
      begin
         randomizePattern();
         executeRun();
      end
      reverse = 1'b0;

      // heavy stalls with both engines busy
      readyPct = 25;
      pingPong = 1'b1;
      repeat (4)
      begin
         extAddr = ext_t'($urandom);
         intAddr = addr_t'(pick(0, DEPTH - 1));
         size    = size_t'(pick(1, 512));
         randomizePattern();
         executeRun();
      end

      // read back the whole buffer
      readyPct   = 70;
      pingPong   = 1'b0;
      size       = '0;
      start      = '0;
      incr       = addr_t'(1);
      shift      = '0;
      period     = per_t'(32);
      duty       = per_t'(32);
      iterations = addr_t'(32);
      delay      = '0;
      executeRun();

      $display("errors: %0d failed checks, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0)
      begin
         $display("SIMULATION PASSED");
      end
      else
      begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

/* streamReader_properties.sv */
`timescale 1ns/1ns

`include "streamReader_cfg.svh"

module streamReader_properties
(
   input logic                          clk,
   input logic                          rst,
   input logic                          busValid,
   input logic [`SR_EXT_ADDR_W-1:0]     busAddr,
   input logic                          busReady,
   input logic                          done,
   input logic                          outValid,
   input streamReaderPkg::fetchState_t  fetchState
);

   // request holds until the memory side takes it
   assert property (@(posedge clk) disable iff (rst)
      busValid && !busReady |=> busValid && $stable(busAddr))
      else $error("busValid dropped or busAddr moved before busReady");

   assert property (@(posedge clk) $fell(rst) |-> done)
      else $error("done low when reset was released");

   // the last word of a run may share its cycle with the rising done
   assert property (@(posedge clk) disable iff (rst)
      fetchState == streamReaderPkg::FETCH_IDLE && done && $past(done) |-> !outValid)
      else $error("outValid high while the reader is idle");

endmodule

bind streamReader streamReader_properties i_properties
(
   .clk        (clk),
   .rst        (rst),
   .busValid   (busValid),
   .busAddr    (busAddr),
   .busReady   (busReady),
   .done       (done),
   .outValid   (outValid),
   .fetchState (i_fetchCtrl.state)
);

/* streamReader.sv */
`timescale 1ns/1ns

`include "streamReader_cfg.svh"

module streamReader
(
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       run,
   output logic                       done,

   // external memory bus
   output logic                       busValid,
   output logic [`SR_EXT_ADDR_W-1:0]  busAddr,
   input  logic                       busReady,
   input  logic [`SR_DATA_W-1:0]      busRdata,

   // output stream, no back-pressure
   output logic                       outValid,
   output logic [`SR_DATA_W-1:0]      outData,

   // configuration, stable during a run
   input  logic [`SR_EXT_ADDR_W-1:0]  extAddr,
   input  logic [`SR_ADDR_W-1:0]      intAddr,
   input  logic [`SR_SIZE_W-1:0]      size,
   input  logic                       pingPong,
   input  logic [`SR_ADDR_W-1:0]      iterations,
   input  logic [`SR_PERIOD_W-1:0]    period,
   input  logic [`SR_PERIOD_W-1:0]    duty,
   input  logic [`SR_ADDR_W-1:0]      start,
   input  logic [`SR_ADDR_W-1:0]      shift,
   input  logic [`SR_ADDR_W-1:0]      incr,
   input  logic [`SR_PERIOD_W-1:0]    delay,
   input  logic                       reverse
);

   logic fetchDone;
   logic readDone;
   logic bank;

   ramPortIf ramBus();

   fetchCtrl i_fetchCtrl
   (
      .clk       (clk),
      .rst       (rst),
      .run       (run),
      .pingPong  (pingPong),
      .extAddr   (extAddr),
      .intAddr   (intAddr),
      .size      (size),
      .busReady  (busReady),
      .busRdata  (busRdata),
      .busValid  (busValid),
      .busAddr   (busAddr),
      .bank      (bank),
      .fetchDone (fetchDone),
      .wr        (ramBus)
   );

   readAddrGen i_readAddrGen
   (
      .clk        (clk),
      .rst        (rst),
      .run        (run),
      .bank       (bank),
      .pingPong   (pingPong),
      .reverse    (reverse),
      .iterations (iterations),
      .period     (period),
      .duty       (duty),
      .delay      (delay),
      .start      (start),
      .shift      (shift),
      .incr       (incr),
      .readDone   (readDone),
      .rd         (ramBus)
   );

   bufferRam i_bufferRam
   (
      .clk (clk),
      .mem (ramBus)
   );

   // rData lags rEn by one cycle
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         outValid <= 1'b0;
      end
      else
      begin
         outValid <= ramBus.rEn;
      end
   end

   assign outData = ramBus.rData;
   assign done    = fetchDone & readDone;

endmodule

/* readAddrGen.sv */
`timescale 1ns/1ns

`include "streamReader_cfg.svh"

module readAddrGen
(
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     run,
   input  logic                     bank,
   input  logic                     pingPong,
   input  logic                     reverse,
   input  logic [`SR_ADDR_W-1:0]    iterations,
   input  logic [`SR_PERIOD_W-1:0]  period,
   input  logic [`SR_PERIOD_W-1:0]  duty,
   input  logic [`SR_PERIOD_W-1:0]  delay,
   input  logic [`SR_ADDR_W-1:0]    start,
   input  logic [`SR_ADDR_W-1:0]    shift,
   input  logic [`SR_ADDR_W-1:0]    incr,
   output logic                     readDone,
   ramPortIf.reader                 rd
);

   streamReaderPkg::readState_t   state;
   logic [`SR_PERIOD_W-1:0]       delayCnt;
   logic [`SR_PERIOD_W-1:0]       perCnt;
   logic [`SR_ADDR_W-1:0]         iterCnt;
   logic [`SR_ADDR_W-1:0]         runAddr;
   logic [`SR_ADDR_W-1:0]         nextAddr;
   logic [`SR_ADDR_W-1:0]         bankAddr;
   logic                          lastPer;
   logic                          lastIter;
   logic                          en;

   function automatic logic [`SR_ADDR_W-1:0] bitRev(input logic [`SR_ADDR_W-1:0] a);
      logic [`SR_ADDR_W-1:0] r;
      for (int i = 0; i < `SR_ADDR_W; i++)
      begin
         r[i] = a[`SR_ADDR_W-1-i];
      end
      return r;
   endfunction

   assign en       = (state == streamReaderPkg::READ_RUN) && (perCnt < duty);
   assign lastPer  = (perCnt == period - 1'b1);
   assign lastIter = (iterCnt == iterations - 1'b1);

   always_comb
   begin
      nextAddr = runAddr;
      if (en)
      begin
         nextAddr = nextAddr + incr;
      end
      if (lastPer)
      begin
         nextAddr = nextAddr + shift;
      end
   end

   // read the bank that the previous run filled
   assign bankAddr = pingPong ? {~bank, runAddr[`SR_ADDR_W-2:0]} : runAddr;
   assign rd.rAddr = reverse ? bitRev(bankAddr) : bankAddr;
   assign rd.rEn   = en;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state    <= streamReaderPkg::READ_IDLE;
         delayCnt <= '0;
         perCnt   <= '0;
         iterCnt  <= '0;
         runAddr  <= '0;
         readDone <= 1'b1;
      end
      else
      begin
         case (state)
            streamReaderPkg::READ_IDLE:
            begin
               // an empty pattern leaves readDone high
               if (run && iterations != '0 && period != '0)
               begin
                  readDone <= 1'b0;
                  delayCnt <= delay;
                  perCnt   <= '0;
                  iterCnt  <= '0;
                  runAddr  <= start;
                  if (delay == '0)
                  begin
                     state <= streamReaderPkg::READ_RUN;
                  end
                  else
                  begin
                     state <= streamReaderPkg::READ_DELAY;
                  end
               end
            end
            streamReaderPkg::READ_DELAY:
            begin
               delayCnt <= delayCnt - 1'b1;
               if (delayCnt == 1)
               begin
                  state <= streamReaderPkg::READ_RUN;
               end
            end
            streamReaderPkg::READ_RUN:
            begin
               runAddr <= nextAddr;
               perCnt  <= lastPer ? '0 : perCnt + 1'b1;
               if (lastPer)
               begin
                  iterCnt <= iterCnt + 1'b1;
                  if (lastIter)
                  begin
                     readDone <= 1'b1;
                     state    <= streamReaderPkg::READ_IDLE;
                  end
               end
            end
            default:
            begin
               state <= streamReaderPkg::READ_IDLE;
            end
         endcase
      end
   end

endmodule

/* fetchCtrl.sv */
`timescale 1ns/1ns

`include "streamReader_cfg.svh"

module fetchCtrl
(
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       run,
   input  logic                       pingPong,
   input  logic [`SR_EXT_ADDR_W-1:0]  extAddr,
   input  logic [`SR_ADDR_W-1:0]      intAddr,
   input  logic [`SR_SIZE_W-1:0]      size,
   input  logic                       busReady,
   input  logic [`SR_DATA_W-1:0]      busRdata,
   output logic                       busValid,
   output logic [`SR_EXT_ADDR_W-1:0]  busAddr,
   output logic                       bank,
   output logic                       fetchDone,
   ramPortIf.writer                   wr
);

   streamReaderPkg::fetchState_t   state;
   logic [`SR_SIZE_W-1:0]          wordCnt;
   logic [`SR_EXT_ADDR_W-1:0]      curAddr;
   logic [`SR_ADDR_W-1:0]          sumAddr;
   logic                           xfer;
   logic                           lastWord;

   assign xfer     = busValid & busReady;
   assign lastWord = (wordCnt == size - 1'b1);

   assign busValid = (state == streamReaderPkg::FETCH_REQ);
   assign busAddr  = curAddr;

   // buffer write in the transfer cycle itself
   assign sumAddr  = intAddr + wordCnt[`SR_ADDR_W-1:0];
   assign wr.wEn   = xfer;
   assign wr.wData = busRdata;
   assign wr.wAddr = pingPong ? {bank, sumAddr[`SR_ADDR_W-2:0]} : sumAddr;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state     <= streamReaderPkg::FETCH_IDLE;
         wordCnt   <= '0;
         curAddr   <= '0;
         bank      <= 1'b0;
         fetchDone <= 1'b1;
      end
      else
      begin
         case (state)
            streamReaderPkg::FETCH_IDLE:
            begin
               if (run)
               begin
                  // flip banks every run, pin to bank 0 otherwise
                  bank      <= pingPong ? ~bank : 1'b0;
                  fetchDone <= 1'b0;
                  wordCnt   <= '0;
                  curAddr   <= extAddr;
                  if (size == '0)
                  begin
                     state <= streamReaderPkg::FETCH_DONE;
                  end
                  else
                  begin
                     state <= streamReaderPkg::FETCH_REQ;
                  end
               end
            end
            streamReaderPkg::FETCH_REQ:
            begin
               if (xfer)
               begin
                  curAddr <= curAddr + 1'b1;
                  wordCnt <= wordCnt + 1'b1;
                  if (lastWord)
                  begin
                     fetchDone <= 1'b1;
                     state     <= streamReaderPkg::FETCH_IDLE;
                  end
               end
            end
            // empty burst
            streamReaderPkg::FETCH_DONE:
            begin
               fetchDone <= 1'b1;
               state     <= streamReaderPkg::FETCH_IDLE;
            end
            default:
            begin
               state <= streamReaderPkg::FETCH_IDLE;
            end
         endcase
      end
   end

endmodule

/* bufferRam.sv */
`timescale 1ns/1ns

`include "streamReader_cfg.svh"

module bufferRam
(
   input  logic     clk,
   ramPortIf.ram    mem
);

   localparam int DEPTH = 2 ** `SR_ADDR_W;

   logic [`SR_DATA_W-1:0] memArr [0:DEPTH-1];

   always_ff @(posedge clk)
   begin
      if (mem.wEn)
      begin
         memArr[mem.wAddr] <= mem.wData;
      end
   end

   // read during write returns the old word
   always_ff @(posedge clk)
   begin
      if (mem.rEn)
      begin
         mem.rData <= memArr[mem.rAddr];
      end
   end

endmodule

/* ramPortIf.sv */
`timescale 1ns/1ns

`include "streamReader_cfg.svh"

interface ramPortIf;

   // write port
   logic                    wEn;
   logic [`SR_ADDR_W-1:0]   wAddr;
   logic [`SR_DATA_W-1:0]   wData;

   // read port, data one cycle after rEn
   logic                    rEn;
   logic [`SR_ADDR_W-1:0]   rAddr;
   logic [`SR_DATA_W-1:0]   rData;

   modport writer
   (
      output wEn, wAddr, wData
   );

   modport reader
   (
      output rEn, rAddr
   );

   modport ram
   (
      input  wEn, wAddr, wData, rEn, rAddr,
      output rData
   );

endinterface

/* streamReaderPkg.sv */
package streamReaderPkg;

   // fetch controller states
   typedef enum logic [1:0]
   {
      FETCH_IDLE = 2'd0,
      FETCH_REQ  = 2'd1,
      FETCH_DONE = 2'd2
   } fetchState_t;

   // read address generator states
   typedef enum logic [1:0]
   {
      READ_IDLE  = 2'd0,
      READ_DELAY = 2'd1,
      READ_RUN   = 2'd2
   } readState_t;

endpackage

/* streamReader_cfg.svh */
`ifndef STREAMREADER_CFG_SVH
`define STREAMREADER_CFG_SVH

// bus and stream word width
`define SR_DATA_W 32

// buffer address width, MSB is the bank bit in ping-pong mode
`define SR_ADDR_W 10

// external word address width
`define SR_EXT_ADDR_W 32

// burst length, wide enough for a full buffer
`define SR_SIZE_W 11

// period, duty and delay counters
`define SR_PERIOD_W 10

`endif
